// ==== hdl/bitparse_pkg.sv ====
package bitparse_pkg;

  localparam int word_w = 128;
  localparam int buf_w = 255;
  localparam int max_blk_bits = 128;
  localparam int fill_w = 8;
  localparam int num_px = 16;
  localparam int max_res_bits = 7;
  localparam int bpv_bits = 6;
  localparam int bpv_fls_offset = 32;
  localparam int num_sub = 4;
  localparam int res_w = 8;
  localparam int bpv_w = 7;

  typedef enum logic [2:0] {
    mode_xfm    = 3'd0,
    mode_bp     = 3'd1,
    mode_mpp    = 3'd2,
    mode_mppf   = 3'd3,
    mode_bpskip = 3'd4
  } mode_t;

  typedef enum logic [1:0] {
    csc_rgb   = 2'd0,
    csc_ycocg = 2'd1
  } csc_t;

  typedef struct packed {
    logic [word_w-1:0] data;
  } stream_word_t;

  // flat_type 4 means not flat
  typedef struct packed {
    mode_t                           mode;
    logic [2:0]                      flat_type;
    csc_t                            csc;
    logic [2:0]                      step_size;
    logic [num_sub-1:0]              use2x2;
    logic [2*num_sub-1:0][bpv_w-1:0] bpv;
    logic [num_px-1:0][res_w-1:0]    residual;
  } block_rec_t;

  // mpp residual width shrinks with the step size
  function automatic int unsigned res_width(input logic [2:0] step);
    return max_res_bits - int'(step);
  endfunction

  // first line of slice uses one bit less
  function automatic int unsigned bpv_width(input logic fls);
    return fls ? bpv_bits - 1 : bpv_bits;
  endfunction

  function automatic logic [bpv_w-1:0] bpv_offset(input logic fls);
    return fls ? bpv_w'(bpv_fls_offset) : '0;
  endfunction

endpackage

// ==== hdl/word_fetch.sv ====
`timescale 1ns/10ps
module word_fetch
(
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              start,
  output logic                              wb_cyc,
  output logic                              wb_stb,
  output logic [31:0]                       wb_adr,
  input  logic [bitparse_pkg::word_w-1:0]   wb_dat_i,
  input  logic                              wb_ack,
  output bitparse_pkg::stream_word_t        word,
  output logic                              word_valid,
  input  logic                              word_take
);

  logic run;
  logic busy;
  logic slot_free;

  // prefetch slot empty or emptied this cycle
  assign slot_free = !word_valid || word_take;

  assign wb_cyc = busy;
  assign wb_stb = busy;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      run        <= 1'b0;
      busy       <= 1'b0;
      wb_adr     <= '0;
      word_valid <= 1'b0;
    end
    else if (start)
    begin
      run        <= 1'b1;
      busy       <= 1'b1;
      wb_adr     <= '0;
      word_valid <= 1'b0;
    end
    else if (busy && wb_ack)
    begin
      busy       <= 1'b0;
      wb_adr     <= wb_adr + 32'd1;
      word_valid <= 1'b1;
    end
    else
    begin
      if (word_take)
        word_valid <= 1'b0;
      if (run && !busy && slot_free)
        busy <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (busy && wb_ack)
      word.data <= wb_dat_i;
  end

endmodule

// ==== hdl/funnel_shifter.sv ====
`timescale 1ns/10ps
module funnel_shifter
(
  input  logic                              clk,
  input  logic                              rstn,
  input  bitparse_pkg::stream_word_t        word,
  input  logic                              word_valid,
  output logic                              word_take,
  output logic [bitparse_pkg::word_w-1:0]   window,
  output logic                              window_full,
  input  logic [bitparse_pkg::fill_w-1:0]   blk_len,
  input  logic                              dec_take
);
  import bitparse_pkg::*;

  logic [buf_w-1:0]  bits;
  logic [fill_w-1:0] fullness;
  logic [fill_w-1:0] used;
  logic [fill_w-1:0] remain;
  logic [buf_w-1:0]  kept;
  logic [buf_w-1:0]  landed;

  assign used   = dec_take ? blk_len : '0;
  assign remain = fullness - used;

  // room for a whole word after this cycle's consumption
  assign word_take = word_valid && (remain < fill_w'(word_w));

  // msb first, bits below the fill point are always zero
  assign kept = bits << used;

  // new word lands right after the remaining bits
  assign landed = {word.data, {(buf_w-word_w){1'b0}}} >> remain;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      bits     <= '0;
      fullness <= '0;
    end
    else if (word_take)
    begin
      bits     <= kept | landed;
      fullness <= remain + fill_w'(word_w);
    end
    else
    begin
      bits     <= kept;
      fullness <= remain;
    end
  end

  assign window      = bits[buf_w-1 -: word_w];
  assign window_full = fullness >= fill_w'(max_blk_bits);

endmodule

// ==== hdl/block_decoder.sv ====
`timescale 1ns/10ps
module block_decoder
(
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              fls,
  input  logic [bitparse_pkg::word_w-1:0]   window,
  input  logic                              window_full,
  output logic [bitparse_pkg::fill_w-1:0]   blk_len,
  output bitparse_pkg::block_rec_t          dec_rec,
  output logic                              dec_valid,
  input  logic                              dec_take
);
  import bitparse_pkg::*;

  mode_t prev_mode;

  // n bits from bit pos of the window, right aligned
  function automatic logic [max_res_bits-1:0] field
  (
    input logic [word_w-1:0] w,
    input int unsigned       pos,
    input int unsigned       n
  );
    logic [word_w-1:0] s;
    s = w << pos;
    return s[word_w-1 -: max_res_bits] >> (max_res_bits - n);
  endfunction

  always_comb
  begin
    int unsigned       pos;
    int unsigned       rw;
    int unsigned       bw;
    logic [bpv_w-1:0]  off;
    dec_rec = '0;
    rw      = 0;
    bw      = 0;
    off     = '0;

    // mode header
    if (window[word_w-1])
    begin
      dec_rec.mode = prev_mode;
      pos          = 1;
    end
    else if (window[word_w-2 -: 2] == 2'b11)
    begin
      dec_rec.mode = window[word_w-4] ? mode_bpskip : mode_mppf;
      pos          = 4;
    end
    else
    begin
      dec_rec.mode = mode_t'({1'b0, window[word_w-2 -: 2]});
      pos          = 3;
    end

    // flatness header
    if (|field(window, pos, 1))
    begin
      dec_rec.flat_type = 3'(field(window, pos + 1, 2));
      pos               = pos + 3;
    end
    else
    begin
      dec_rec.flat_type = 3'd4;
      pos               = pos + 1;
    end

    case (dec_rec.mode)
      mode_mpp:
      begin
        dec_rec.csc       = |field(window, pos, 1) ? csc_ycocg : csc_rgb;
        dec_rec.step_size = 3'(field(window, pos + 1, 3));
        pos               = pos + 4;
        rw                = res_width(dec_rec.step_size);
        for (int k = 0; k < num_px; k++)
        begin
          dec_rec.residual[k] = res_w'(field(window, pos, rw));
          pos                 = pos + rw;
        end
      end
      mode_bp:
      begin
        bw  = bpv_width(fls);
        off = bpv_offset(fls);
        for (int k = 0; k < num_sub; k++)
          dec_rec.use2x2[k] = |field(window, pos + k, 1);
        pos = pos + num_sub;
        // one bpv per 2x2 subblock, two otherwise
        for (int k = 0; k < num_sub; k++)
        begin
          dec_rec.bpv[2*k] = bpv_w'(field(window, pos, bw)) + off;
          pos              = pos + bw;
          if (!dec_rec.use2x2[k])
          begin
            dec_rec.bpv[2*k+1] = bpv_w'(field(window, pos, bw)) + off;
            pos                = pos + bw;
          end
        end
      end
      // xfm, mppf and bpskip carry their headers only
      default: ;
    endcase

    blk_len = fill_w'(pos);
  end

  assign dec_valid = window_full;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      prev_mode <= mode_xfm;
    else if (dec_take)
      prev_mode <= dec_rec.mode;
  end

endmodule

// ==== hdl/block_out.sv ====
`timescale 1ns/10ps
module block_out
(
  input  logic                        clk,
  input  logic                        rstn,
  input  bitparse_pkg::block_rec_t    dec_rec,
  input  logic                        dec_valid,
  output logic                        dec_take,
  output bitparse_pkg::block_rec_t    out_rec,
  output logic                        out_valid,
  input  logic                        out_ready
);

  // accept while empty or draining this cycle
  assign dec_take = dec_valid && (!out_valid || out_ready);

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      out_valid <= 1'b0;
    else if (dec_take)
      out_valid <= 1'b1;
    else if (out_ready)
      out_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (dec_take)
      out_rec <= dec_rec;
  end

endmodule

// ==== hdl/bitparse_top.sv ====
`timescale 1ns/10ps
module bitparse_top
(
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              start,
  input  logic                              fls,
  output logic                              wb_cyc,
  output logic                              wb_stb,
  output logic [31:0]                       wb_adr,
  input  logic [bitparse_pkg::word_w-1:0]   wb_dat_i,
  input  logic                              wb_ack,
  output bitparse_pkg::block_rec_t          out_rec,
  output logic                              out_valid,
  input  logic                              out_ready
);
  import bitparse_pkg::*;

  stream_word_t      word;
  logic              word_valid;
  logic              word_take;
  logic [word_w-1:0] window;
  logic              window_full;
  logic [fill_w-1:0] blk_len;
  block_rec_t        dec_rec;
  logic              dec_valid;
  logic              dec_take;

  word_fetch u_fetch
  (
    .clk        (clk),
    .rstn       (rstn),
    .start      (start),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_adr     (wb_adr),
    .wb_dat_i   (wb_dat_i),
    .wb_ack     (wb_ack),
    .word       (word),
    .word_valid (word_valid),
    .word_take  (word_take)
  );

  funnel_shifter u_funnel
  (
    .clk         (clk),
    .rstn        (rstn),
    .word        (word),
    .word_valid  (word_valid),
    .word_take   (word_take),
    .window      (window),
    .window_full (window_full),
    .blk_len     (blk_len),
    .dec_take    (dec_take)
  );

  block_decoder u_dec
  (
    .clk         (clk),
    .rstn        (rstn),
    .fls         (fls),
    .window      (window),
    .window_full (window_full),
    .blk_len     (blk_len),
    .dec_rec     (dec_rec),
    .dec_valid   (dec_valid),
    .dec_take    (dec_take)
  );

  block_out u_out
  (
    .clk       (clk),
    .rstn      (rstn),
    .dec_rec   (dec_rec),
    .dec_valid (dec_valid),
    .dec_take  (dec_take),
    .out_rec   (out_rec),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

// ==== tb/bitparse_chk.sv ====
`timescale 1ns/10ps
module bitparse_chk
(
  input logic                              clk,
  input logic                              rstn,
  input logic                              wb_cyc,
  input logic                              wb_stb,
  input logic                              wb_ack,
  input logic [31:0]                       wb_adr,
  input logic                              out_valid,
  input logic                              out_ready,
  input bitparse_pkg::block_rec_t          out_rec,
  input logic [bitparse_pkg::fill_w-1:0]   fullness,
  input logic [bitparse_pkg::fill_w-1:0]   used,
  input logic                              word_take
);
  import bitparse_pkg::*;

  // request held with a steady address until acked
  stb_held: assert property (@(posedge clk) disable iff (!rstn)
    wb_stb && !wb_ack |=> wb_stb && wb_cyc && $stable(wb_adr))
    else $error("wb request dropped or address changed before ack");

  // stalled record must not change
  rec_held: assert property (@(posedge clk) disable iff (!rstn)
    out_valid && !out_ready |=> out_valid && $stable(out_rec))
    else $error("out_rec changed while stalled");

  // next fullness at full width, a wrap would show here
  fill_bound: assert property (@(posedge clk) disable iff (!rstn)
    int'(used) <= int'(fullness) &&
    int'(fullness) - int'(used) + (word_take ? word_w : 0) <= buf_w)
    else $error("funnel fullness out of range");

endmodule

bind bitparse_top bitparse_chk u_chk
(
  .clk       (clk),
  .rstn      (rstn),
  .wb_cyc    (wb_cyc),
  .wb_stb    (wb_stb),
  .wb_ack    (wb_ack),
  .wb_adr    (wb_adr),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_rec   (out_rec),
  .fullness  (u_funnel.fullness),
  .used      (u_funnel.used),
  .word_take (u_funnel.word_take)
);

// ==== tb/bitparse_tb.sv ====
`timescale 1ns/10ps
module bitparse_tb;
  import bitparse_pkg::*;

  localparam int num_words = 64;
  localparam int stream_len = num_words * word_w;
  localparam int num_phases = 3;
  localparam int period_ns = 100;
  localparam int cycles_per_word = 40;

  logic              clk;
  logic              rstn;
  logic              start;
  logic              fls;
  logic              wb_cyc;
  logic              wb_stb;
  logic [31:0]       wb_adr;
  logic [word_w-1:0] wb_dat_i;
  logic              wb_ack;
  block_rec_t        out_rec;
  logic              out_valid;
  logic              out_ready;

  logic [word_w-1:0] mem [num_words];
  logic [31:0]       lfsr;
  block_rec_t        exp_q[$];
  logic              running;
  int                phase;
  int                n_exp;
  int                n_got;
  int                acked;
  int                wait_left;

  bitparse_top dut
  (
    .clk       (clk),
    .rstn      (rstn),
    .start     (start),
    .fls       (fls),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_adr    (wb_adr),
    .wb_dat_i  (wb_dat_i),
    .wb_ack    (wb_ack),
    .out_rec   (out_rec),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // right shift galois form, x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // stream bits msb first, word 0 leads
  function automatic logic [31:0] get_bits(input int pos, input int n);
    logic [31:0] v;
    int          w;
    int          b;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      w = (pos + i) / word_w;
      b = word_w - 1 - (pos + i) % word_w;
      v = {v[30:0], mem[w][b]};
    end
    return v;
  endfunction

  task automatic build_model(input logic fl);
    block_rec_t  r;
    mode_t       prev;
    int          pos;
    int          rw;
    int          bw;
    logic [6:0]  off;
    logic [31:0] v;
    exp_q.delete();
    prev = mode_xfm;
    pos  = 0;
    bw   = fl ? bpv_bits - 1 : bpv_bits;
    off  = fl ? 7'(bpv_fls_offset) : 7'd0;
    // only blocks whose whole window lies inside the stream
    while (pos + max_blk_bits <= stream_len)
    begin
      r = '0;
      v = get_bits(pos, 3);
      if (v[2])
      begin
        r.mode = prev;
        pos    = pos + 1;
      end
      else if (v[1:0] == 2'b11)
      begin
        v      = get_bits(pos + 3, 1);
        r.mode = v[0] ? mode_bpskip : mode_mppf;
        pos    = pos + 4;
      end
      else
      begin
        r.mode = mode_t'({1'b0, v[1:0]});
        pos    = pos + 3;
      end
      v = get_bits(pos, 3);
      r.flat_type = v[2] ? {1'b0, v[1:0]} : 3'd4;
      pos = pos + (v[2] ? 3 : 1);
      if (r.mode == mode_mpp)
      begin
        v           = get_bits(pos, 4);
        r.csc       = v[3] ? csc_ycocg : csc_rgb;
        r.step_size = v[2:0];
        pos         = pos + 4;
        rw          = max_res_bits - int'(r.step_size);
        for (int k = 0; k < num_px; k++)
        begin
          r.residual[k] = 8'(get_bits(pos, rw));
          pos           = pos + rw;
        end
      end
      else if (r.mode == mode_bp)
      begin
        v        = get_bits(pos, 4);
        r.use2x2 = {v[0], v[1], v[2], v[3]};
        pos      = pos + 4;
        for (int k = 0; k < num_sub; k++)
        begin
          r.bpv[2*k] = 7'(get_bits(pos, bw)) + off;
          pos        = pos + bw;
          if (!r.use2x2[k])
          begin
            r.bpv[2*k+1] = 7'(get_bits(pos, bw)) + off;
            pos          = pos + bw;
          end
        end
      end
      exp_q.push_back(r);
      prev = r.mode;
    end
  endtask

  task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
    if (exp !== act)
    begin
      $display("Fail %s: expected %0h, actual %0h", name, exp, act);
      $display("Regression failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic compare_rec(input block_rec_t e, input block_rec_t a, input int idx);
    string t;
    t = $sformatf("phase %0d block %0d", phase, idx);
    check({t, " mode"}, 128'(e.mode), 128'(a.mode));
    check({t, " flat_type"}, 128'(e.flat_type), 128'(a.flat_type));
    check({t, " csc"}, 128'(e.csc), 128'(a.csc));
    check({t, " step_size"}, 128'(e.step_size), 128'(a.step_size));
    check({t, " use2x2"}, 128'(e.use2x2), 128'(a.use2x2));
    for (int k = 0; k < 2 * num_sub; k++)
      check($sformatf("%s bpv %0d", t, k), 128'(e.bpv[k]), 128'(a.bpv[k]));
    for (int k = 0; k < num_px; k++)
      check($sformatf("%s residual %0d", t, k), 128'(e.residual[k]), 128'(a.residual[k]));
  endtask

  // wishbone slave and output sink, one draw order per cycle
  initial
  begin
    logic [31:0] v;
    block_rec_t  e;
    wb_ack    = 1'b0;
    wb_dat_i  = '0;
    out_ready = 1'b1;
    wait_left = -1;
    forever
    begin
      @(posedge clk);
      #1;
      wb_ack = 1'b0;
      if (running)
      begin
        draw(2, v);
        out_ready = v[1:0] != 2'b00;
        if (!(wb_cyc && wb_stb))
          wait_left = -1;
        else
        begin
          if (wait_left < 0)
          begin
            draw(2, v);
            wait_left = int'(v[1:0]);
          end
          if (wait_left == 0)
          begin
            check($sformatf("phase %0d wb_adr", phase), 128'(acked), 128'(wb_adr));
            wb_dat_i  = mem[wb_adr[5:0]];
            wb_ack    = 1'b1;
            acked     = acked + 1;
            wait_left = -1;
          end
          else
            wait_left = wait_left - 1;
        end
        // transfer completes at the next edge
        if (out_valid && out_ready && n_got < n_exp)
        begin
          e = exp_q.pop_front();
          compare_rec(e, out_rec, n_got);
          n_got = n_got + 1;
        end
      end
      else
      begin
        out_ready = 1'b1;
        wait_left = -1;
      end
    end
  end

  initial
  begin
    logic [31:0] v;
    rstn    = 1'b0;
    start   = 1'b0;
    fls     = 1'b0;
    running = 1'b0;
    lfsr    = 32'h141c_eb81;
    phase   = 0;
    n_exp   = 0;
    n_got   = 0;
    acked   = 0;
    for (int p = 0; p < num_phases; p++)
    begin
      phase = p;
      rstn  = 1'b0;
      for (int w = 0; w < num_words; w++)
      begin
        for (int i = 0; i < word_w / 32; i++)
        begin
          draw(32, v);
          mem[w][i*32 +: 32] = v;
        end
      end
      draw(1, v);
      // both fls values first, then a random one
      fls = (p == 0) ? 1'b0 : ((p == 1) ? 1'b1 : v[0]);
      build_model(fls);
      n_exp = exp_q.size();
      n_got = 0;
      acked = 0;
      repeat (5) @(posedge clk);
      #1;
      rstn = 1'b1;
      running <= 1'b1;
      repeat (2)
      begin
        @(posedge clk);
        #1;
        check($sformatf("phase %0d wb_cyc before start", p), 128'(0), 128'(wb_cyc));
        check($sformatf("phase %0d out_valid before start", p), 128'(0), 128'(out_valid));
      end
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      check($sformatf("phase %0d wb_cyc after start", p), 128'(1), 128'(wb_cyc));
      check($sformatf("phase %0d wb_stb after start", p), 128'(1), 128'(wb_stb));
      while (n_got < n_exp)
        @(posedge clk);
      #1;
      running <= 1'b0;
      @(posedge clk);
      #1;
    end
    $display("Regression passed");
    $finish;
  end

  initial
  begin
    #(num_phases * (num_words * cycles_per_word + 20) * period_ns);
    $display("Watchdog: the run did not finish in time, %0d of %0d blocks seen", n_got, n_exp);
    $display("Regression failed");
    $fatal(1, "timeout");
  end

endmodule

// ==== bitparse_top.f ====
hdl/bitparse_pkg.sv
hdl/word_fetch.sv
hdl/funnel_shifter.sv
hdl/block_decoder.sv
hdl/block_out.sv
hdl/bitparse_top.sv
tb/bitparse_chk.sv
tb/bitparse_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= bitparse_tb
FILELIST  ?= bitparse_top.f
BUILD     ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# the simulator exit status carries pass or fail
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
